//--- verilog.f
+incdir+rtl
rtl/aes_pkg.sv
rtl/aes_key_sched.sv
rtl/aes_round.sv
rtl/aes_core.sv
rtl/aes_io_regs.sv
rtl/aes_top.sv
dv/aes_props.sv
dv/aes_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the AES testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module aes_tb -f verilog.f -o aes_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/aes_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "Test passed" sim.log; then
  exit 0
fi
exit 1

//--- dv/aes_tb.sv
`timescale 1ns/1ps
`include "aes_consts.svh"

module aes_tb;
  import aes_pkg::*;

  localparam int N_REQ   = 26;
  localparam int MAX_CYC = 20 * N_REQ + 100;

  logic       clk;
  logic       rst_n;
  logic       start;
  aes_block_t plaintext;
  aes_block_t key;
  aes_block_t ciphertext;
  logic       done;
  logic       busy;

  int          cyc;
  int          errors;
  int          checks;
  int          err0;
  logic [31:0] lfsr;
  aes_block_t  exp_q [$];
  int          start_q [$];
  aes_block_t  pt;
  aes_block_t  k;

  aes_top DUT (
    .clk        (clk),
    .rst_n      (rst_n),
    .start      (start),
    .plaintext  (plaintext),
    .key        (key),
    .ciphertext (ciphertext),
    .done       (done),
    .busy       (busy)
  );

  always #10 clk = ~clk;

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic rand_block(output aes_block_t b);
    for (int i = 0; i < 128; i++) begin
      lfsr = lfsr_step(lfsr);
      b = {b[126:0], lfsr[0]};
    end
  endtask

  function automatic aes_byte_t gmul(input aes_byte_t a, input aes_byte_t b);
    aes_byte_t p;
    aes_byte_t x;
    p = 8'h00;
    x = a;
    for (int i = 0; i < 8; i++) begin
      if (b[i]) p = p ^ x;
      x = x[7] ? ((x << 1) ^ 8'h1b) : (x << 1);
    end
    return p;
  endfunction

  // FIPS-197 cipher on a 4x4 state indexed s[row][col]
  function automatic aes_block_t aes_ref(input aes_block_t p_in, input aes_block_t k_in);
    aes_byte_t  s [4][4];
    aes_byte_t  t [4][4];
    aes_word_t  w [44];
    aes_word_t  tmp;
    aes_byte_t  rc;
    aes_block_t out;
    rc = 8'h01;
    for (int i = 0; i < 4; i++) w[i] = k_in[127-32*i -: 32];
    for (int i = 4; i < 44; i++) begin
      tmp = w[i-1];
      if (i % 4 == 0) begin
        tmp = {tmp[23:0], tmp[31:24]};
        tmp = {AES_SBOX[tmp[31:24]], AES_SBOX[tmp[23:16]],
               AES_SBOX[tmp[15:8]], AES_SBOX[tmp[7:0]]};
        tmp[31:24] = tmp[31:24] ^ rc;
        rc = gmul(rc, 8'h02);
      end
      w[i] = w[i-4] ^ tmp;
    end
    for (int c = 0; c < 4; c++) begin
      for (int r = 0; r < 4; r++) s[r][c] = p_in[127-8*(4*c+r) -: 8] ^ w[c][31-8*r -: 8];
    end
    for (int rnd = 1; rnd <= `AES_NR; rnd++) begin
      // SubBytes and ShiftRows in one pass
      for (int c = 0; c < 4; c++) begin
        for (int r = 0; r < 4; r++) t[r][c] = AES_SBOX[s[r][(c+r)%4]];
      end
      for (int c = 0; c < 4; c++) begin
        for (int r = 0; r < 4; r++) begin
          if (rnd == `AES_NR) s[r][c] = t[r][c];
          else s[r][c] = gmul(t[r][c], 8'h02) ^ gmul(t[(r+1)%4][c], 8'h03)
                       ^ t[(r+2)%4][c] ^ t[(r+3)%4][c];
          s[r][c] = s[r][c] ^ w[4*rnd+c][31-8*r -: 8];
        end
      end
    end
    for (int c = 0; c < 4; c++) begin
      for (int r = 0; r < 4; r++) out[127-8*(4*c+r) -: 8] = s[r][c];
    end
    return out;
  endfunction

  task automatic check_block(input aes_block_t got, input aes_block_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  // Called 2 ns after a rising edge and returns 2 ns after the sampling edge
  task automatic pulse_start(input aes_block_t p_in, input aes_block_t k_in, input bit tracked);
    start     = 1'b1;
    plaintext = p_in;
    key       = k_in;
    if (tracked) begin
      exp_q.push_back(aes_ref(p_in, k_in));
      start_q.push_back(cyc + 1);
    end
    @(posedge clk);
    #2;
    start = 1'b0;
  endtask

  task automatic wait_done();
    do begin
      @(posedge clk);
      #2;
    end while (!done);
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
    #2;
  endtask

  task automatic end_test(input string name);
    // Lets the falling-edge compare of the last done land in this test
    wait_cycles(1);
    $display("%s: %s", name, (errors == err0) ? "ok" : "FAILED");
    err0 = errors;
  endtask

  always @(posedge clk) begin
    cyc = cyc + 1;
    if (cyc >= MAX_CYC) begin
      $display("Timeout: run did not finish within %0d cycles", MAX_CYC);
      $display("Test failed");
      $finish;
    end
  end

  // Results compared at the falling edge
  always @(negedge clk) begin
    if (rst_n && done) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("ERR %0t: done with no request outstanding", $time);
      end else begin
        check_block(ciphertext, exp_q.pop_front(), "ciphertext");
        checks++;
        if (cyc - start_q[0] != 11) begin
          errors++;
          $display("ERR %0t: done %0d cycles after start, expected 11", $time,
                   cyc - start_q[0]);
        end
        void'(start_q.pop_front());
      end
    end
  end

  initial begin
    clk       = 1'b0;
    rst_n     = 1'b0;
    start     = 1'b0;
    plaintext = '0;
    key       = '0;
    cyc       = 0;
    errors    = 0;
    checks    = 0;
    err0      = 0;
    lfsr      = 32'hfeb6_2f33;
    wait_cycles(5);
    rst_n = 1'b1;

    // Appendix C.1
    pt = 128'h00112233_44556677_8899aabb_ccddeeff;
    k  = 128'h00010203_04050607_08090a0b_0c0d0e0f;
    check_block(aes_ref(pt, k), 128'h69c4e0d8_6a7b0430_d8cdb780_70b4c55a, "model vs FIPS");
    exp_q.push_back(128'h69c4e0d8_6a7b0430_d8cdb780_70b4c55a);
    start_q.push_back(cyc + 1);
    pulse_start(pt, k, 1'b0);
    wait_done();
    end_test("fips_vector");

    for (int i = 0; i < 20; i++) begin
      rand_block(pt);
      rand_block(k);
      pulse_start(pt, k, 1'b1);
      wait_done();
      check_bit(busy, 1'b0, "busy after done");
    end
    end_test("random_20");

    rand_block(pt);
    rand_block(k);
    pulse_start(pt, k, 1'b1);
    pulse_start(~pt, k, 1'b0);
    check_bit(busy, 1'b1, "busy during request");
    wait_cycles(9);
    // Sampled on the same edge that raises done
    pulse_start(pt, ~k, 1'b0);
    check_bit(done, 1'b1, "done at edge 11");
    wait_cycles(5);
    check_bit(busy, 1'b0, "busy after ignored starts");
    end_test("start_while_busy");

    rand_block(pt);
    rand_block(k);
    pulse_start(pt, k, 1'b1);
    wait_done();
    rand_block(pt);
    pulse_start(pt, k, 1'b1);
    wait_done();
    end_test("back_to_back");

    rand_block(pt);
    rand_block(k);
    pulse_start(pt, k, 1'b0);
    wait_cycles(4);
    rst_n = 1'b0;
    wait_cycles(5);
    rst_n = 1'b1;
    check_bit(busy, 1'b0, "busy after reset");
    check_bit(done, 1'b0, "done after reset");
    check_block(ciphertext, '0, "ciphertext after reset");
    pulse_start(pt, k, 1'b1);
    wait_done();
    end_test("reset_mid_request");

    wait_cycles(5);
    if (exp_q.size() != 0) begin
      errors++;
      $display("%0d expected results never arrived", exp_q.size());
    end
    $display("checks passed %0d, errors %0d", checks - errors, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- dv/aes_props.sv
`timescale 1ns/1ps

module aes_props (
  input logic clk,
  input logic rst_n,
  input logic start,
  input logic done,
  input logic busy
);

  // Edges seen since the last accepted start, 0 when idle
  logic [3:0] age;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      age <= '0;
    end else if (start && !busy) begin
      age <= 4'd1;
    end else if (age != 4'd0 && age != 4'd12) begin
      age <= age + 4'd1;
    end else begin
      age <= '0;
    end
  end

  a_done_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
    done |=> !done) else $error("done held for more than one cycle");

  a_done_after_busy: assert property (@(posedge clk) disable iff (!rst_n)
    done |-> $past(busy)) else $error("done without busy in the previous cycle");

  a_busy_falls_with_done: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(busy) |-> done) else $error("busy fell without done");

  // Start edge plus 11 edges, seen one sample later
  a_done_latency: assert property (@(posedge clk) disable iff (!rst_n)
    (age == 4'd12) == done) else $error("done not 11 cycles after accepted start");

endmodule

bind aes_top aes_props u_props (
  .clk   (clk),
  .rst_n (rst_n),
  .start (start),
  .done  (done),
  .busy  (busy)
);

//--- rtl/aes_top.sv
`timescale 1ns/1ps

module aes_top (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                start,
  input  aes_pkg::aes_block_t plaintext,
  input  aes_pkg::aes_block_t key,
  output aes_pkg::aes_block_t ciphertext,
  output logic                done,
  output logic                busy
);
  import aes_pkg::*;

  logic       load;
  logic       last;
  aes_block_t pt_q;
  aes_block_t key_q;
  aes_block_t result;

  aes_io_regs u_io_regs (
    .clk        (clk),
    .rst_n      (rst_n),
    .start      (start),
    .plaintext  (plaintext),
    .key        (key),
    .last       (last),
    .result     (result),
    .load       (load),
    .pt_q       (pt_q),
    .key_q      (key_q),
    .ciphertext (ciphertext),
    .done       (done),
    .busy       (busy)
  );

  aes_core u_core (
    .clk    (clk),
    .rst_n  (rst_n),
    .load   (load),
    .pt_q   (pt_q),
    .key_q  (key_q),
    .last   (last),
    .result (result)
  );

endmodule

//--- rtl/aes_io_regs.sv
`timescale 1ns/1ps

module aes_io_regs (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                start,
  input  aes_pkg::aes_block_t plaintext,
  input  aes_pkg::aes_block_t key,
  input  logic                last,
  input  aes_pkg::aes_block_t result,
  output logic                load,
  output aes_pkg::aes_block_t pt_q,
  output aes_pkg::aes_block_t key_q,
  output aes_pkg::aes_block_t ciphertext,
  output logic                done,
  output logic                busy
);

  logic accept;

  // Starts while busy are dropped
  assign accept = start && !busy;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      load       <= 1'b0;
      done       <= 1'b0;
      busy       <= 1'b0;
      ciphertext <= '0;
    end else begin
      load <= accept;
      done <= last;
      if (accept) begin
        busy <= 1'b1;
      end else if (last) begin
        busy <= 1'b0;
      end
      if (last) begin
        ciphertext <= result;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      pt_q  <= plaintext;
      key_q <= key;
    end
  end

endmodule

//--- rtl/aes_core.sv
`timescale 1ns/1ps
`include "aes_consts.svh"

module aes_core (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                load,
  input  aes_pkg::aes_block_t pt_q,
  input  aes_pkg::aes_block_t key_q,
  output logic                last,
  output aes_pkg::aes_block_t result
);
  import aes_pkg::*;

  aes_core_state_e       fsm_q;
  logic [`AES_RND_W-1:0] rnd_q;
  aes_block_t            state_q;
  aes_block_t            round_key;
  aes_block_t            round_out;
  logic                  run;
  logic                  final_rnd;

  assign run       = (fsm_q == RUN);
  assign final_rnd = (rnd_q == `AES_RND_W'(`AES_NR));
  assign last      = run && final_rnd;
  assign result    = round_out;

  aes_key_sched u_key_sched (
    .clk       (clk),
    .rst_n     (rst_n),
    .load      (load),
    .step      (run),
    .key_in    (key_q),
    .round_key (round_key)
  );

  aes_round u_round (
    .state_in  (state_q),
    .round_key (round_key),
    .final_rnd (final_rnd),
    .state_out (round_out)
  );

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fsm_q <= IDLE;
      rnd_q <= '0;
    end else if (load) begin
      fsm_q <= RUN;
      rnd_q <= `AES_RND_W'(1);
    end else if (run) begin
      if (final_rnd) begin
        fsm_q <= IDLE;
        rnd_q <= '0;
      end else begin
        rnd_q <= rnd_q + 1'b1;
      end
    end
  end

  // Initial AddRoundKey on load, then one round per cycle
  always_ff @(posedge clk) begin
    if (load) begin
      state_q <= pt_q ^ key_q;
    end else if (run) begin
      state_q <= round_out;
    end
  end

endmodule

//--- rtl/aes_round.sv
`timescale 1ns/1ps

module aes_round (
  input  aes_pkg::aes_block_t state_in,
  input  aes_pkg::aes_block_t round_key,
  input  logic                final_rnd,
  output aes_pkg::aes_block_t state_out
);
  import aes_pkg::*;

  aes_byte_t sb [16];
  aes_byte_t sr [16];
  aes_byte_t mc [16];

  function automatic aes_byte_t xtime(input aes_byte_t b);
    return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
  endfunction

  always_comb begin
    // SubBytes
    for (int i = 0; i < 16; i++) begin
      sb[i] = AES_SBOX[state_in[127-8*i -: 8]];
    end

    // Row r rotates left by r columns
    for (int c = 0; c < 4; c++) begin
      for (int r = 0; r < 4; r++) begin
        sr[4*c+r] = sb[4*((c+r)%4)+r];
      end
    end

    // MixColumns, 2*a[r] ^ 3*a[r+1] ^ a[r+2] ^ a[r+3]
    for (int c = 0; c < 4; c++) begin
      for (int r = 0; r < 4; r++) begin
        mc[4*c+r] = xtime(sr[4*c+r])
                  ^ xtime(sr[4*c+(r+1)%4])
                  ^ sr[4*c+(r+1)%4]
                  ^ sr[4*c+(r+2)%4]
                  ^ sr[4*c+(r+3)%4];
      end
    end

    // AddRoundKey, last round skips the mix
    for (int i = 0; i < 16; i++) begin
      state_out[127-8*i -: 8] = (final_rnd ? sr[i] : mc[i]) ^ round_key[127-8*i -: 8];
    end
  end

endmodule

//--- rtl/aes_key_sched.sv
`timescale 1ns/1ps

module aes_key_sched (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                load,
  input  logic                step,
  input  aes_pkg::aes_block_t key_in,
  output aes_pkg::aes_block_t round_key
);
  import aes_pkg::*;

  aes_block_t rk_q;
  aes_byte_t  rcon_q;
  aes_word_t  w    [4];
  aes_word_t  nw   [4];
  aes_word_t  rot;
  aes_word_t  temp;

  // Next round key from the current one
  always_comb begin
    for (int i = 0; i < 4; i++) begin
      w[i] = rk_q[127-32*i -: 32];
    end
    rot = {w[3][23:0], w[3][31:24]};
    for (int b = 0; b < 4; b++) begin
      temp[31-8*b -: 8] = AES_SBOX[rot[31-8*b -: 8]];
    end
    temp     = temp ^ {rcon_q, 24'h000000};
    nw[0]    = w[0] ^ temp;
    for (int i = 1; i < 4; i++) begin
      nw[i] = w[i] ^ nw[i-1];
    end
    round_key = {nw[0], nw[1], nw[2], nw[3]};
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rcon_q <= 8'h01;
    end else if (load) begin
      rcon_q <= 8'h01;
    end else if (step) begin
      // Doubling in GF(2^8)
      rcon_q <= {rcon_q[6:0], 1'b0} ^ (rcon_q[7] ? 8'h1b : 8'h00);
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      rk_q <= key_in;
    end else if (step) begin
      rk_q <= round_key;
    end
  end

endmodule

//--- rtl/aes_pkg.sv
`include "aes_consts.svh"

package aes_pkg;

  typedef logic [7:0]              aes_byte_t;
  typedef logic [31:0]             aes_word_t;
  // Byte 0 sits in the top bits, columns of four bytes
  typedef logic [`AES_BLOCK_W-1:0] aes_block_t;

  typedef enum logic {
    IDLE,
    RUN
  } aes_core_state_e;

  // Forward S-box
  localparam aes_byte_t AES_SBOX [256] = '{
    8'h63, 8'h7c, 8'h77, 8'h7b, 8'hf2, 8'h6b, 8'h6f, 8'hc5,
    8'h30, 8'h01, 8'h67, 8'h2b, 8'hfe, 8'hd7, 8'hab, 8'h76,
    8'hca, 8'h82, 8'hc9, 8'h7d, 8'hfa, 8'h59, 8'h47, 8'hf0,
    8'had, 8'hd4, 8'ha2, 8'haf, 8'h9c, 8'ha4, 8'h72, 8'hc0,
    8'hb7, 8'hfd, 8'h93, 8'h26, 8'h36, 8'h3f, 8'hf7, 8'hcc,
    8'h34, 8'ha5, 8'he5, 8'hf1, 8'h71, 8'hd8, 8'h31, 8'h15,
    8'h04, 8'hc7, 8'h23, 8'hc3, 8'h18, 8'h96, 8'h05, 8'h9a,
    8'h07, 8'h12, 8'h80, 8'he2, 8'heb, 8'h27, 8'hb2, 8'h75,
    8'h09, 8'h83, 8'h2c, 8'h1a, 8'h1b, 8'h6e, 8'h5a, 8'ha0,
    8'h52, 8'h3b, 8'hd6, 8'hb3, 8'h29, 8'he3, 8'h2f, 8'h84,
    8'h53, 8'hd1, 8'h00, 8'hed, 8'h20, 8'hfc, 8'hb1, 8'h5b,
    8'h6a, 8'hcb, 8'hbe, 8'h39, 8'h4a, 8'h4c, 8'h58, 8'hcf,
    8'hd0, 8'hef, 8'haa, 8'hfb, 8'h43, 8'h4d, 8'h33, 8'h85,
    8'h45, 8'hf9, 8'h02, 8'h7f, 8'h50, 8'h3c, 8'h9f, 8'ha8,
    8'h51, 8'ha3, 8'h40, 8'h8f, 8'h92, 8'h9d, 8'h38, 8'hf5,
    8'hbc, 8'hb6, 8'hda, 8'h21, 8'h10, 8'hff, 8'hf3, 8'hd2,
    8'hcd, 8'h0c, 8'h13, 8'hec, 8'h5f, 8'h97, 8'h44, 8'h17,
    8'hc4, 8'ha7, 8'h7e, 8'h3d, 8'h64, 8'h5d, 8'h19, 8'h73,
    8'h60, 8'h81, 8'h4f, 8'hdc, 8'h22, 8'h2a, 8'h90, 8'h88,
    8'h46, 8'hee, 8'hb8, 8'h14, 8'hde, 8'h5e, 8'h0b, 8'hdb,
    8'he0, 8'h32, 8'h3a, 8'h0a, 8'h49, 8'h06, 8'h24, 8'h5c,
    8'hc2, 8'hd3, 8'hac, 8'h62, 8'h91, 8'h95, 8'he4, 8'h79,
    8'he7, 8'hc8, 8'h37, 8'h6d, 8'h8d, 8'hd5, 8'h4e, 8'ha9,
    8'h6c, 8'h56, 8'hf4, 8'hea, 8'h65, 8'h7a, 8'hae, 8'h08,
    8'hba, 8'h78, 8'h25, 8'h2e, 8'h1c, 8'ha6, 8'hb4, 8'hc6,
    8'he8, 8'hdd, 8'h74, 8'h1f, 8'h4b, 8'hbd, 8'h8b, 8'h8a,
    8'h70, 8'h3e, 8'hb5, 8'h66, 8'h48, 8'h03, 8'hf6, 8'h0e,
    8'h61, 8'h35, 8'h57, 8'hb9, 8'h86, 8'hc1, 8'h1d, 8'h9e,
    8'he1, 8'hf8, 8'h98, 8'h11, 8'h69, 8'hd9, 8'h8e, 8'h94,
    8'h9b, 8'h1e, 8'h87, 8'he9, 8'hce, 8'h55, 8'h28, 8'hdf,
    8'h8c, 8'ha1, 8'h89, 8'h0d, 8'hbf, 8'he6, 8'h42, 8'h68,
    8'h41, 8'h99, 8'h2d, 8'h0f, 8'hb0, 8'h54, 8'hbb, 8'h16
  };

endpackage

//--- rtl/aes_consts.svh
`ifndef AES_CONSTS_SVH
`define AES_CONSTS_SVH

// AES-128 block size
`define AES_BLOCK_W 128

// Rounds and round counter width
`define AES_NR      10
`define AES_RND_W   4

`endif
